// ==== project.f ====
+incdir+.
cpu_pkg.sv
ctrl_if.sv
fetch_unit.sv
decoder.sv
reg_file.sv
exec_unit.sv
branch_unit.sv
core_top.sv
tb_core.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_core
FILELIST  = project.f

OBJ_DIR = obj_dir
SIM     = $(OBJ_DIR)/V$(TOP)
LOG     = sim.log
SOURCES = $(shell grep -v '^+' $(FILELIST)) tb_program.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_program.svh ====
// program table for tb_core: one row per presented instruction with the expected core response
// columns: instruction, pc when presented, wb_en, wb_addr, wb_data, illegal
// wb_addr and wb_data are compared only on rows that expect wb_en high
task automatic load_program();
    // arithmetic and logic, x1 = 5 and x2 = -3 feed most rows
    add_row(i_type(opc_imm, 3'b000, 5'd1, 5'd0, 12'd5), 32'h100, 1'b1, 5'd1, 32'h5, 1'b0);
    add_row(i_type(opc_imm, 3'b000, 5'd2, 5'd0, -12'sd3), 32'h104, 1'b1, 5'd2, 32'hffff_fffd, 1'b0);
    add_row(r_type(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), 32'h108, 1'b1, 5'd3, 32'h2, 1'b0);  // add
    add_row(r_type(7'h20, 3'b000, 5'd4, 5'd1, 5'd2), 32'h10c, 1'b1, 5'd4, 32'h8, 1'b0);  // sub
    add_row(r_type(7'h20, 3'b000, 5'd5, 5'd2, 5'd1), 32'h110, 1'b1, 5'd5, 32'hffff_fff8, 1'b0);
    add_row(r_type(7'h00, 3'b111, 5'd6, 5'd1, 5'd2), 32'h114, 1'b1, 5'd6, 32'h5, 1'b0);  // and
    add_row(r_type(7'h00, 3'b110, 5'd7, 5'd1, 5'd2), 32'h118, 1'b1, 5'd7, 32'hffff_fffd, 1'b0);
    add_row(r_type(7'h00, 3'b100, 5'd8, 5'd1, 5'd2), 32'h11c, 1'b1, 5'd8, 32'hffff_fff8, 1'b0);
    add_row(r_type(7'h00, 3'b010, 5'd9, 5'd2, 5'd1), 32'h120, 1'b1, 5'd9, 32'h1, 1'b0);   // slt
    add_row(r_type(7'h00, 3'b011, 5'd10, 5'd2, 5'd1), 32'h124, 1'b1, 5'd10, 32'h0, 1'b0); // sltu
    add_row(r_type(7'h00, 3'b001, 5'd11, 5'd1, 5'd1), 32'h128, 1'b1, 5'd11, 32'ha0, 1'b0);
    add_row(r_type(7'h00, 3'b101, 5'd12, 5'd2, 5'd1), 32'h12c, 1'b1, 5'd12, 32'h07ff_ffff, 1'b0);
    add_row(r_type(7'h20, 3'b101, 5'd13, 5'd2, 5'd1), 32'h130, 1'b1, 5'd13, 32'hffff_ffff, 1'b0);
    // immediate forms
    add_row(i_type(opc_imm, 3'b111, 5'd14, 5'd2, 12'h0f0), 32'h134, 1'b1, 5'd14, 32'hf0, 1'b0);
    add_row(i_type(opc_imm, 3'b110, 5'd15, 5'd1, -12'sd16), 32'h138, 1'b1, 5'd15, 32'hffff_fff5, 1'b0);
    add_row(i_type(opc_imm, 3'b100, 5'd16, 5'd2, -12'sd1), 32'h13c, 1'b1, 5'd16, 32'h2, 1'b0);
    add_row(i_type(opc_imm, 3'b010, 5'd17, 5'd2, -12'sd2), 32'h140, 1'b1, 5'd17, 32'h1, 1'b0);
    add_row(i_type(opc_imm, 3'b011, 5'd18, 5'd1, -12'sd1), 32'h144, 1'b1, 5'd18, 32'h1, 1'b0);
    add_row(i_type(opc_imm, 3'b001, 5'd19, 5'd1, 12'd28), 32'h148, 1'b1, 5'd19, 32'h5000_0000, 1'b0);
    add_row(i_type(opc_imm, 3'b101, 5'd20, 5'd2, 12'd4), 32'h14c, 1'b1, 5'd20, 32'h0fff_ffff, 1'b0);
    add_row(i_type(opc_imm, 3'b101, 5'd21, 5'd5, 12'h402), 32'h150, 1'b1, 5'd21, 32'hffff_fffe, 1'b0);
    // upper immediates
    add_row(u_type(opc_lui, 5'd22, 20'h12345), 32'h154, 1'b1, 5'd22, 32'h1234_5000, 1'b0);
    add_row(u_type(opc_auipc, 5'd23, 20'h00001), 32'h158, 1'b1, 5'd23, 32'h0000_1158, 1'b0);
    // x0 stays zero, then an unknown opcode
    add_row(i_type(opc_imm, 3'b000, 5'd0, 5'd1, 12'd7), 32'h15c, 1'b0, 5'd0, 32'h0, 1'b0);
    add_row(r_type(7'h00, 3'b000, 5'd24, 5'd0, 5'd1), 32'h160, 1'b1, 5'd24, 32'h5, 1'b0);
    add_row(32'hffff_ffff, 32'h164, 1'b0, 5'd0, 32'h0, 1'b1);
    // each condition taken, then not taken
    add_row(b_type(3'b000, 5'd1, 5'd1, 13'd8), 32'h168, 1'b0, 5'd0, 32'h0, 1'b0);
    add_row(b_type(3'b000, 5'd1, 5'd2, 13'd8), 32'h170, 1'b0, 5'd0, 32'h0, 1'b0);
    add_row(b_type(3'b001, 5'd1, 5'd2, 13'd12), 32'h174, 1'b0, 5'd0, 32'h0, 1'b0);
    add_row(b_type(3'b001, 5'd1, 5'd1, 13'd8), 32'h180, 1'b0, 5'd0, 32'h0, 1'b0);
    add_row(b_type(3'b100, 5'd2, 5'd1, 13'd8), 32'h184, 1'b0, 5'd0, 32'h0, 1'b0);
    add_row(b_type(3'b100, 5'd1, 5'd2, 13'd8), 32'h18c, 1'b0, 5'd0, 32'h0, 1'b0);
    add_row(b_type(3'b101, 5'd1, 5'd2, 13'd8), 32'h190, 1'b0, 5'd0, 32'h0, 1'b0);
    add_row(b_type(3'b101, 5'd2, 5'd1, 13'd8), 32'h198, 1'b0, 5'd0, 32'h0, 1'b0);
    add_row(b_type(3'b110, 5'd1, 5'd2, 13'd8), 32'h19c, 1'b0, 5'd0, 32'h0, 1'b0);
    add_row(b_type(3'b110, 5'd2, 5'd1, 13'd8), 32'h1a4, 1'b0, 5'd0, 32'h0, 1'b0);
    add_row(b_type(3'b111, 5'd2, 5'd1, -13'sd40), 32'h1a8, 1'b0, 5'd0, 32'h0, 1'b0);  // backward
    add_row(b_type(3'b111, 5'd1, 5'd2, 13'd8), 32'h180, 1'b0, 5'd0, 32'h0, 1'b0);
    // jumps and link values
    add_row(j_type(5'd25, 21'd16), 32'h184, 1'b1, 5'd25, 32'h188, 1'b0);
    add_row(i_type(opc_imm, 3'b000, 5'd26, 5'd0, 12'h201), 32'h194, 1'b1, 5'd26, 32'h201, 1'b0);
    add_row(i_type(opc_jalr, 3'b000, 5'd27, 5'd26, 12'h010), 32'h198, 1'b1, 5'd27, 32'h19c, 1'b0);
    add_row(i_type(opc_jalr, 3'b000, 5'd0, 5'd25, 12'd0), 32'h210, 1'b0, 5'd0, 32'h0, 1'b0);
    add_row(r_type(7'h00, 3'b000, 5'd28, 5'd27, 5'd25), 32'h188, 1'b1, 5'd28, 32'h324, 1'b0);
    add_row(i_type(opc_imm, 3'b000, 5'd30, 5'd28, -12'sd804), 32'h18c, 1'b1, 5'd30, 32'h0, 1'b0);
endtask

// ==== tb_core.sv ====
// testbench for core_top: acts as program memory and checks pc and write-back against a table
`timescale 1ns/1ns
module tb_core;

    localparam logic [31:0] reset_pc      = 32'h0000_0100;
    localparam int          clk_period    = 10;
    localparam int          reset_cycles  = 4;
    localparam int          margin_cycles = 20;

    localparam logic [6:0] opc_imm   = 7'h13;
    localparam logic [6:0] opc_lui   = 7'h37;
    localparam logic [6:0] opc_auipc = 7'h17;
    localparam logic [6:0] opc_jalr  = 7'h67;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;       // pc expected when inst is presented
        logic        wb_en;
        logic [4:0]  wb_addr;
        logic [31:0] wb_data;
        logic        illegal;
    } step_t;

    logic        clk;
    logic        reset;
    logic [31:0] inst;
    logic [31:0] pc;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic        illegal;

    step_t prog [$];
    int    row_errors;
    int    pass_count;
    int    fail_count;
    int    limit_ns = 0;

    core_top #(
        .reset_pc(reset_pc)
    ) i_dut (
        .clk    (clk),
        .reset  (reset),
        .inst   (inst),
        .pc     (pc),
        .wb_en  (wb_en),
        .wb_addr(wb_addr),
        .wb_data(wb_data),
        .illegal(illegal)
    );

    // instruction encoders, opcode 0x33 for register form
    function automatic logic [31:0] r_type(input logic [6:0] funct7, input logic [2:0] funct3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {funct7, rs2, rs1, funct3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] opcode, input logic [2:0] funct3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic logic [31:0] u_type(input logic [6:0] opcode, input logic [4:0] rd,
                                           input logic [19:0] imm);
        return {imm, rd, opcode};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] funct3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    task automatic add_row(input logic [31:0] word, input logic [31:0] exp_pc,
                           input logic en, input logic [4:0] addr,
                           input logic [31:0] data, input logic ill);
        step_t s;
        s.inst    = word;
        s.pc      = exp_pc;
        s.wb_en   = en;
        s.wb_addr = addr;
        s.wb_data = data;
        s.illegal = ill;
        prog.push_back(s);
    endtask

    `include "tb_program.svh"

    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[ERROR] %s expected 0x%h actual 0x%h", name, expected, actual);
            row_errors++;
        end
    endtask

    task automatic report_test(input string label);
        if (row_errors == 0) begin
            $display("%s: ok", label);
            pass_count++;
        end else begin
            $display("%s: %0d mismatch(es)", label, row_errors);
            fail_count++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        wait (limit_ns != 0);
        #(limit_ns);
        $display("timeout: the program did not complete within %0d ns", limit_ns);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        reset      = 1'b1;
        inst       = '0;
        pass_count = 0;
        fail_count = 0;
        load_program();
        limit_ns = (prog.size() + reset_cycles + margin_cycles) * clk_period;

        // words that would write or trap must stay silent under reset
        row_errors = 0;
        for (int c = 0; c < reset_cycles; c++) begin
            @(posedge clk);
            inst <= (c < 2) ? i_type(opc_imm, 3'b000, 5'd1, 5'd0, 12'd5) : 32'hffff_ffff;
            @(negedge clk);
            check_field("pc", reset_pc, pc);
            check_field("wb_en", 32'h0, 32'(wb_en));
            check_field("illegal", 32'h0, 32'(illegal));
        end
        report_test("reset");

        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            reset <= 1'b0;  // released on the first fetch edge
            inst  <= prog[i].inst;
            @(negedge clk);
            row_errors = 0;
            check_field("pc", prog[i].pc, pc);
            check_field("wb_en", 32'(prog[i].wb_en), 32'(wb_en));
            check_field("illegal", 32'(prog[i].illegal), 32'(illegal));
            if (prog[i].wb_en) begin
                check_field("wb_addr", 32'(prog[i].wb_addr), 32'(wb_addr));
                check_field("wb_data", prog[i].wb_data, wb_data);
            end
            report_test($sformatf("row %0d pc 0x%h inst 0x%h", i, prog[i].pc, prog[i].inst));
        end

        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== core_top.sv ====
// single-cycle RV32I core top level; program memory and write-back observation sit outside
`timescale 1ns/1ns
module core_top #(
    parameter logic [cpu_pkg::xlen-1:0] reset_pc = 32'h8000_0000
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [cpu_pkg::xlen-1:0]       inst,     // word at the current pc
    output logic [cpu_pkg::xlen-1:0]       pc,
    output logic                           wb_en,
    output logic [cpu_pkg::reg_addr_w-1:0] wb_addr,
    output logic [cpu_pkg::xlen-1:0]       wb_data,
    output logic                           illegal
);
    import cpu_pkg::*;

    logic [xlen-1:0]       snpc;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [xlen-1:0]       rdata1;
    logic [xlen-1:0]       rdata2;
    logic [xlen-1:0]       alu_result;
    logic                  redirect;
    logic [xlen-1:0]       target;

    ctrl_if ctl ();

    fetch_unit #(
        .reset_pc(reset_pc)
    ) u_fetch (
        .clk     (clk),
        .reset   (reset),
        .redirect(redirect),
        .target  (target),
        .pc      (pc),
        .snpc    (snpc)
    );

    decoder u_decoder (
        .reset  (reset),
        .inst   (inst),
        .rs1    (rs1),
        .rs2    (rs2),
        .illegal(illegal),
        .ctl    (ctl.ctrl)
    );

    reg_file u_reg_file (
        .clk   (clk),
        .raddr1(rs1),
        .raddr2(rs2),
        .rdata1(rdata1),
        .rdata2(rdata2),
        .wdata (wb_data),
        .ctl   (ctl.rf)
    );

    exec_unit u_exec (
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .pc        (pc),
        .snpc      (snpc),
        .alu_result(alu_result),
        .wb_data   (wb_data),
        .ctl       (ctl.dp)
    );

    branch_unit u_branch (
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .alu_result(alu_result),
        .redirect  (redirect),
        .target    (target),
        .ctl       (ctl.dp)
    );

    // write-back port mirrors what the register file commits at the next edge
    assign wb_en   = ctl.reg_write;
    assign wb_addr = ctl.rd;

endmodule

// ==== branch_unit.sv ====
// branch condition evaluation and redirect target for conditional branches and jumps
`timescale 1ns/1ns
module branch_unit (
    input  logic [cpu_pkg::xlen-1:0] rdata1,
    input  logic [cpu_pkg::xlen-1:0] rdata2,
    input  logic [cpu_pkg::xlen-1:0] alu_result,
    output logic                     redirect,
    output logic [cpu_pkg::xlen-1:0] target,
    ctrl_if.dp                       ctl
);
    import cpu_pkg::*;

    logic taken;

    always_comb begin
        taken = 1'b0;
        if (ctl.branch) begin
            case (ctl.funct3)
                3'b000:  taken = (rdata1 == rdata2);                   // beq
                3'b001:  taken = (rdata1 != rdata2);                   // bne
                3'b100:  taken = ($signed(rdata1) < $signed(rdata2));  // blt
                3'b101:  taken = ($signed(rdata1) >= $signed(rdata2)); // bge
                3'b110:  taken = (rdata1 < rdata2);                    // bltu
                3'b111:  taken = (rdata1 >= rdata2);                   // bgeu
                default: taken = 1'b0;
            endcase
        end
    end

    assign redirect = taken || ctl.jump;

    // bit 0 cleared for jalr targets
    assign target = {alu_result[xlen-1:1], 1'b0};

endmodule

// ==== exec_unit.sv ====
// execute stage: operand muxing, the ALU and selection of the write-back value
`timescale 1ns/1ns
module exec_unit (
    input  logic [cpu_pkg::xlen-1:0] rdata1,
    input  logic [cpu_pkg::xlen-1:0] rdata2,
    input  logic [cpu_pkg::xlen-1:0] pc,
    input  logic [cpu_pkg::xlen-1:0] snpc,
    output logic [cpu_pkg::xlen-1:0] alu_result,
    output logic [cpu_pkg::xlen-1:0] wb_data,
    ctrl_if.dp                       ctl
);
    import cpu_pkg::*;

    logic [xlen-1:0]         op_a;
    logic [xlen-1:0]         op_b;
    logic [xlen:0]           diff_ext;  // extra msb holds the borrow
    logic [xlen-1:0]         diff;
    logic                    overflow;
    logic                    slt_res;
    logic                    sltu_res;
    logic [$clog2(xlen)-1:0] shamt;

    always_comb begin
        case (ctl.src_a)
            src_a_pc:   op_a = pc;
            src_a_zero: op_a = '0;
            default:    op_a = rdata1;
        endcase
    end

    assign op_b  = (ctl.src_b == src_b_imm) ? ctl.imm : rdata2;
    assign shamt = op_b[$clog2(xlen)-1:0];

    // one subtractor serves sub, slt and sltu
    assign diff_ext = {1'b0, op_a} - {1'b0, op_b};
    assign diff     = diff_ext[xlen-1:0];
    assign overflow = (op_a[xlen-1] != op_b[xlen-1]) && (diff[xlen-1] != op_a[xlen-1]);
    assign slt_res  = diff[xlen-1] ^ overflow;
    assign sltu_res = diff_ext[xlen];  // borrow out means a < b

    always_comb begin
        case (ctl.alu_op)
            alu_sub:  alu_result = diff;
            alu_and:  alu_result = op_a & op_b;
            alu_or:   alu_result = op_a | op_b;
            alu_xor:  alu_result = op_a ^ op_b;
            alu_slt:  alu_result = {{(xlen-1){1'b0}}, slt_res};
            alu_sltu: alu_result = {{(xlen-1){1'b0}}, sltu_res};
            alu_sll:  alu_result = op_a << shamt;
            alu_srl:  alu_result = op_a >> shamt;
            alu_sra:  alu_result = $unsigned($signed(op_a) >>> shamt);
            default:  alu_result = op_a + op_b;  // add, address forms
        endcase
    end

    assign wb_data = (ctl.wb_sel == wb_link) ? snpc : alu_result;

endmodule

// ==== reg_file.sv ====
// 32 x 32-bit integer register file, two combinational read ports and one clocked write port
`timescale 1ns/1ns
module reg_file (
    input  logic                           clk,
    input  logic [cpu_pkg::reg_addr_w-1:0] raddr1,
    input  logic [cpu_pkg::reg_addr_w-1:0] raddr2,
    output logic [cpu_pkg::xlen-1:0]       rdata1,
    output logic [cpu_pkg::xlen-1:0]       rdata2,
    input  logic [cpu_pkg::xlen-1:0]       wdata,
    ctrl_if.rf                             ctl
);
    import cpu_pkg::*;

    logic [xlen-1:0] regs [2**reg_addr_w];

    always_ff @(posedge clk) begin
        if (ctl.reg_write) begin
            regs[ctl.rd] <= wdata;  // decoder never asserts this for x0
        end
    end

    // x0 reads as zero whatever the array holds
    always_comb begin
        rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
        rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];
    end

endmodule

// ==== decoder.sv ====
// instruction decoder: register addresses, immediate and the control bundle for one RV32I word
`timescale 1ns/1ns
module decoder (
    input  logic                           reset,
    input  logic [cpu_pkg::xlen-1:0]       inst,
    output logic [cpu_pkg::reg_addr_w-1:0] rs1,
    output logic [cpu_pkg::reg_addr_w-1:0] rs2,
    output logic                           illegal,
    ctrl_if.ctrl                           ctl
);
    import cpu_pkg::*;

    opcode_t         opcode;
    logic [2:0]      funct3;
    logic            funct7_b5;  // selects sub and sra
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;
    logic            writes_rd;
    logic            unknown;

    assign opcode    = opcode_t'(inst[6:0]);
    assign funct3    = inst[14:12];
    assign funct7_b5 = inst[30];
    assign rs1       = inst[19:15];
    assign rs2       = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        ctl.alu_op = alu_add;
        ctl.src_a  = src_a_rs1;
        ctl.src_b  = src_b_imm;
        ctl.imm    = imm_i;
        ctl.wb_sel = wb_alu;
        ctl.branch = 1'b0;
        ctl.jump   = 1'b0;
        writes_rd  = 1'b0;
        unknown    = 1'b0;

        case (opcode)
            op_lui: begin
                ctl.src_a = src_a_zero;  // 0 + upper immediate
                ctl.imm   = imm_u;
                writes_rd = 1'b1;
            end
            op_auipc: begin
                ctl.src_a = src_a_pc;
                ctl.imm   = imm_u;
                writes_rd = 1'b1;
            end
            op_jal: begin
                ctl.src_a  = src_a_pc;  // alu forms the target
                ctl.imm    = imm_j;
                ctl.wb_sel = wb_link;
                ctl.jump   = 1'b1;
                writes_rd  = 1'b1;
            end
            op_jalr: begin
                ctl.wb_sel = wb_link;  // rs1 + imm is the target
                ctl.jump   = 1'b1;
                writes_rd  = 1'b1;
            end
            op_branch: begin
                ctl.src_a  = src_a_pc;
                ctl.imm    = imm_b;
                ctl.branch = 1'b1;
            end
            op_imm, op_reg: begin
                if (opcode == op_reg) begin
                    ctl.src_b = src_b_rs2;
                end
                writes_rd = 1'b1;
                case (funct3)
                    3'b000: ctl.alu_op = (opcode == op_reg && funct7_b5) ? alu_sub : alu_add;
                    3'b001: ctl.alu_op = alu_sll;
                    3'b010: ctl.alu_op = alu_slt;
                    3'b011: ctl.alu_op = alu_sltu;
                    3'b100: ctl.alu_op = alu_xor;
                    3'b101: ctl.alu_op = funct7_b5 ? alu_sra : alu_srl;  // srai has bit 30 set too
                    3'b110: ctl.alu_op = alu_or;
                    default: ctl.alu_op = alu_and;
                endcase
            end
            default: begin
                unknown = 1'b1;  // nothing written, pc just advances
            end
        endcase
    end

    assign ctl.rd        = inst[11:7];
    assign ctl.funct3    = funct3;
    assign ctl.reg_write = writes_rd && (inst[11:7] != '0) && !reset;
    assign illegal       = unknown && !reset;

endmodule

// ==== fetch_unit.sv ====
// program counter with sequential and redirected next-pc selection, one update per clock
`timescale 1ns/1ns
module fetch_unit #(
    parameter logic [cpu_pkg::xlen-1:0] reset_pc = 32'h8000_0000
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     redirect,
    input  logic [cpu_pkg::xlen-1:0] target,
    output logic [cpu_pkg::xlen-1:0] pc,
    output logic [cpu_pkg::xlen-1:0] snpc
);
    import cpu_pkg::*;

    logic [xlen-1:0] dnpc;  // next pc actually taken

    assign snpc = pc + xlen'(4);

    always_comb begin
        if (redirect) begin
            dnpc = target;  // taken branch or jump
        end else begin
            dnpc = snpc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else begin
            pc <= dnpc;
        end
    end

endmodule

// ==== ctrl_if.sv ====
// decoded control bundle, driven by the decoder and read by the register file and datapath
`timescale 1ns/1ns
interface ctrl_if;
    import cpu_pkg::*;

    alu_op_t               alu_op;
    src_a_t                src_a;
    src_b_t                src_b;
    logic [xlen-1:0]       imm;
    wb_sel_t               wb_sel;
    logic                  reg_write;  // already low for rd == x0
    logic [reg_addr_w-1:0] rd;
    logic                  branch;     // conditional branch
    logic                  jump;       // jal or jalr
    logic [2:0]            funct3;     // branch condition

    modport ctrl (
        output alu_op, src_a, src_b, imm, wb_sel, reg_write, rd, branch, jump, funct3
    );

    modport dp (
        input alu_op, src_a, src_b, imm, wb_sel, branch, jump, funct3
    );

    modport rf (
        input reg_write, rd
    );

endinterface

// ==== cpu_pkg.sv ====
// shared widths and encodings for the single-cycle RV32I core, imported by every design unit
package cpu_pkg;

    localparam int xlen       = 32;  // data and address width
    localparam int reg_addr_w = 5;   // 32 architectural registers

    // major opcodes kept by this core
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_slt  = 4'd5,   // signed compare, result in bit 0
        alu_sltu = 4'd6,   // unsigned compare
        alu_sll  = 4'd7,
        alu_srl  = 4'd8,
        alu_sra  = 4'd9
    } alu_op_t;

    // first ALU operand
    typedef enum logic [1:0] {
        src_a_rs1  = 2'd0,
        src_a_pc   = 2'd1,   // auipc, branches, jal
        src_a_zero = 2'd2    // lui
    } src_a_t;

    // second ALU operand
    typedef enum logic {
        src_b_rs2 = 1'b0,
        src_b_imm = 1'b1
    } src_b_t;

    // write-back source
    typedef enum logic {
        wb_alu  = 1'b0,
        wb_link = 1'b1   // pc + 4 for jal and jalr
    } wb_sel_t;

endpackage
